// File: Makefile
# Verilator flow for the interrupt and sleep controller

VERILATOR ?= verilator
TOP       ?= irq_ctrl_tb
RTL_TOP   ?= irq_ctrl_top
FILELIST  ?= irq_ctrl_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(wildcard src/*.sv src/*.svh dv/*.sv)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/irq_ctrl_tb.sv
// Testbench with clock, reset, APB tasks, reference model, assertions and watchdog for irq_ctrl_top
`include "irq_ctrl_macros.svh"

module irq_ctrl_tb
  import irq_ctrl_pkg::*;
();

  localparam logic [31:0] VALID_MASK  = `IRQ_VALID_MASK;
  localparam logic [31:0] MST_MIE     = 32'h1 << `MSTATUS_MIE_BIT;
  // Rough length of the whole run in clock cycles
  localparam int          TEST_CYCLES = 1000;

  logic        clk_i;
  logic        rst_ni;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  irq_vec_t    irq;
  logic        irq_ack_o;
  irq_id_t     irq_id_o;
  logic        wfi;
  logic        debug_req;
  bus_status_t instr_bus;
  bus_status_t data_bus;
  logic        core_sleep_o;
  int          seed = 53872;

  irq_ctrl_top i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .apb_req_i    (apb_req),
    .apb_rsp_o    (apb_rsp),
    .irq_i        (irq),
    .irq_ack_o    (irq_ack_o),
    .irq_id_o     (irq_id_o),
    .wfi_i        (wfi),
    .debug_req_i  (debug_req),
    .instr_bus_i  (instr_bus),
    .data_bus_i   (data_bus),
    .core_sleep_o (core_sleep_o)
  );

  always #50 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Failure reporting and value checks
  // ----------------------------------------------------------------------
  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("%s (time %0t)", msg, $time);
    abort_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("mismatch at time %0t: %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  // Priority 31..16 then 11, 3, 7 with the result as {valid, id}
  function automatic logic [5:0] pick_winner(input irq_vec_t pend);
    for (int i = 31; i >= 16; i--) begin
      if (pend[i]) return {1'b1, 5'(i)};
    end
    if (pend[11]) return {1'b1, 5'd11};
    if (pend[3]) return {1'b1, 5'd3};
    if (pend[7]) return {1'b1, 5'd7};
    return 6'd0;
  endfunction

  // +1 on an accepted request, -1 on a response
  function automatic int count_step(input bus_status_t b);
    return int'(b.req & b.gnt) - int'(b.rvalid);
  endfunction

  irq_vec_t     mip_m;
  irq_vec_t     mie_m;
  logic         mst_m;
  logic         ack_m;
  irq_id_t      id_m;
  int           instr_cnt;
  int           data_cnt;
  int           dly_m;
  sleep_state_e sleep_st;
  irq_vec_t     pend_m;
  logic [5:0]   win_m;
  logic         wake_m;
  logic         busy_m;
  logic         apb_wr;

  assign pend_m = mip_m & mie_m;
  assign win_m  = pick_winner(pend_m);
  assign wake_m = (|pend_m) | debug_req;
  assign busy_m = (instr_cnt != 0) || (data_cnt != 0);
  assign apb_wr = apb_req.psel & apb_req.penable & apb_req.pwrite;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_m     <= '0;
      mie_m     <= '0;
      mst_m     <= 1'b0;
      ack_m     <= 1'b0;
      id_m      <= '0;
      instr_cnt <= 0;
      data_cnt  <= 0;
      dly_m     <= 0;
      sleep_st  <= SLEEP_IDLE;
    end else begin
      mip_m <= irq & VALID_MASK;
      if (apb_wr && apb_req.paddr == `CSR_MIE_OFF) mie_m <= apb_req.pwdata & VALID_MASK;
      // Taking an interrupt drops the global enable
      if (ack_m) mst_m <= 1'b0;
      else if (apb_wr && apb_req.paddr == `CSR_MSTATUS_OFF)
        mst_m <= apb_req.pwdata[`MSTATUS_MIE_BIT];
      ack_m     <= win_m[5] && mst_m && !ack_m;
      id_m      <= win_m[4:0];
      instr_cnt <= instr_cnt + count_step(instr_bus);
      data_cnt  <= data_cnt + count_step(data_bus);
      // Sleep sequence
      if (sleep_st == SLEEP_IDLE) begin
        if (wfi && !wake_m) begin
          sleep_st <= SLEEP_DELAY;
          dly_m    <= `WFI_SLEEP_DELAY;
        end
      end else if (wake_m) sleep_st <= SLEEP_IDLE;
      else if (sleep_st == SLEEP_DELAY) begin
        if (dly_m == 1) sleep_st <= busy_m ? SLEEP_DRAIN : SLEEP_ACTIVE;
        else dly_m <= dly_m - 1;
      end else if (sleep_st == SLEEP_DRAIN && !busy_m) sleep_st <= SLEEP_ACTIVE;
    end
  end

  // Registered outputs are compared mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_value("irq_ack_o", 32'(ack_m), 32'(irq_ack_o));
      if (ack_m) check_value("irq_id_o", 32'(id_m), 32'(irq_id_o));
      check_value("core_sleep_o", 32'(sleep_st == SLEEP_ACTIVE), 32'(core_sleep_o));
    end
  end

  ack_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o)
    else report_error("irq_ack_o stayed high for more than one cycle");

  ack_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> VALID_MASK[irq_id_o])
    else report_error("irq_id_o names a reserved interrupt line");

  // ----------------------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------------------
  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    @(negedge clk_i);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    // Response is combinational and is sampled well before the rising edge
    #10;
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // Zero wait states on every access
    check_value("pready", 1, 32'(apb_rsp.pready));
    @(negedge clk_i);
    apb_req = '0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata, input logic exp_err);
    apb_data_t rdata;
    logic      err;
    apb_xfer(1'b1, addr, wdata, rdata, err);
    check_value("pslverr", 32'(exp_err), 32'(err));
  endtask

  task automatic apb_read_check(input apb_addr_t addr, input apb_data_t exp,
                                input logic exp_err);
    apb_data_t rdata;
    logic      err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    check_value("prdata", exp, rdata);
    check_value("pslverr", 32'(exp_err), 32'(err));
  endtask

  task automatic pulse_wfi();
    @(negedge clk_i);
    wfi = 1'b1;
    @(negedge clk_i);
    wfi = 1'b0;
  endtask

  // Entered on the falling edge right after wfi was sampled
  task automatic expect_sleep_after(input int edges);
    for (int i = 0; i < edges; i++) begin
      check_value("core_sleep_o", 0, 32'(core_sleep_o));
      @(negedge clk_i);
    end
    check_value("core_sleep_o", 1, 32'(core_sleep_o));
  endtask

  task automatic wait_ack(input irq_vec_t mie_val);
    int n;
    n = 0;
    while (irq_ack_o !== 1'b1) begin
      if (n == 10) report_error("no interrupt acknowledge within 10 cycles");
      else begin
        n++;
        @(negedge clk_i);
      end
    end
    assert (mie_val[irq_id_o]) else report_error("irq_id_o names a line disabled in MIE");
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    irq_vec_t  irq_val;
    irq_vec_t  mie_val;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    apb_req   = '0;
    irq       = '0;
    wfi       = 1'b0;
    debug_req = 1'b0;
    instr_bus = '0;
    data_bus  = '0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset values and register access
    check_value("irq_ack_o", 0, 32'(irq_ack_o));
    check_value("irq_id_o", 0, 32'(irq_id_o));
    check_value("core_sleep_o", 0, 32'(core_sleep_o));
    check_value("prdata", 0, apb_rsp.prdata);
    check_value("pslverr", 0, 32'(apb_rsp.pslverr));
    apb_read_check(`CSR_MIE_OFF, '0, 1'b0);
    apb_read_check(`CSR_MSTATUS_OFF, '0, 1'b0);
    apb_read_check(`CSR_MIP_OFF, '0, 1'b0);
    for (int i = 0; i < 8; i++) begin
      mie_val = $random(seed);
      apb_write(`CSR_MIE_OFF, mie_val, 1'b0);
      apb_read_check(`CSR_MIE_OFF, mie_val & VALID_MASK, 1'b0);
    end
    apb_write(`CSR_MSTATUS_OFF, 32'hFFFF_FFFF, 1'b0);
    apb_read_check(`CSR_MSTATUS_OFF, MST_MIE, 1'b0);
    apb_write(`CSR_MSTATUS_OFF, ~MST_MIE, 1'b0);
    apb_read_check(`CSR_MSTATUS_OFF, '0, 1'b0);
    apb_read_check(8'h0C, '0, 1'b1);
    apb_write(8'h40, 32'hFFFF_FFFF, 1'b1);
    // A MIP write leaves every register as it was
    apb_write(`CSR_MIP_OFF, 32'hFFFF_FFFF, 1'b0);
    apb_read_check(`CSR_MIP_OFF, '0, 1'b0);
    apb_read_check(`CSR_MIE_OFF, mie_val & VALID_MASK, 1'b0);
    apb_read_check(`CSR_MSTATUS_OFF, '0, 1'b0);
    apb_write(`CSR_MIE_OFF, '0, 1'b0);

    // MIP follows irq_i held steady across each read
    for (int i = 0; i < 8; i++) begin
      irq_val = $random(seed);
      irq     = irq_val;
      apb_read_check(`CSR_MIP_OFF, irq_val & VALID_MASK, 1'b0);
    end

    // Arbitration where odd rounds keep only the low lines enabled
    for (int i = 0; i < 20; i++) begin
      irq     = '0;
      mie_val = $random(seed);
      if (i % 2 == 1) mie_val = mie_val & 32'h0000_0FFF;
      irq_val = $random(seed);
      apb_write(`CSR_MIE_OFF, mie_val, 1'b0);
      apb_write(`CSR_MSTATUS_OFF, MST_MIE, 1'b0);
      irq = irq_val;
      if ((irq_val & mie_val & VALID_MASK) != 0) begin
        wait_ack(mie_val & VALID_MASK);
        irq = '0;
        apb_read_check(`CSR_MSTATUS_OFF, '0, 1'b0);
      end else begin
        repeat (4) @(negedge clk_i);
        apb_read_check(`CSR_MSTATUS_OFF, MST_MIE, 1'b0);
      end
    end

    // Masking by the global enable, then by MIE
    apb_write(`CSR_MSTATUS_OFF, '0, 1'b0);
    apb_write(`CSR_MIE_OFF, VALID_MASK, 1'b0);
    irq = 32'hFFFF_FFFF;
    repeat (6) @(negedge clk_i);
    apb_write(`CSR_MIE_OFF, '0, 1'b0);
    apb_write(`CSR_MSTATUS_OFF, MST_MIE, 1'b0);
    repeat (6) @(negedge clk_i);
    apb_write(`CSR_MSTATUS_OFF, '0, 1'b0);
    irq = '0;

    // Sleep entry with both bus sides idle, then debug wake
    pulse_wfi();
    expect_sleep_after(`WFI_SLEEP_DELAY);
    debug_req = 1'b1;
    @(negedge clk_i);
    check_value("core_sleep_o", 0, 32'(core_sleep_o));
    debug_req = 1'b0;

    // Drain wait on an outstanding data transaction
    @(negedge clk_i);
    data_bus = '{req: 1'b1, gnt: 1'b1, rvalid: 1'b0};
    @(negedge clk_i);
    data_bus = '0;
    pulse_wfi();
    repeat (6) begin
      check_value("core_sleep_o", 0, 32'(core_sleep_o));
      @(negedge clk_i);
    end
    data_bus.rvalid = 1'b1;
    @(negedge clk_i);
    data_bus = '0;
    check_value("core_sleep_o", 0, 32'(core_sleep_o));
    @(negedge clk_i);
    check_value("core_sleep_o", 1, 32'(core_sleep_o));

    // Interrupt wake with the global enable clear
    apb_write(`CSR_MIE_OFF, 32'h0000_0080, 1'b0);
    irq = 32'h0000_0080;
    @(negedge clk_i);
    check_value("core_sleep_o", 1, 32'(core_sleep_o));
    @(negedge clk_i);
    check_value("core_sleep_o", 0, 32'(core_sleep_o));
    // WFI under a live wake is dropped even though the line clears right after it
    @(negedge clk_i);
    wfi = 1'b1;
    irq = '0;
    @(negedge clk_i);
    wfi = 1'b0;
    repeat (4) @(negedge clk_i);
    check_value("core_sleep_o", 0, 32'(core_sleep_o));
    repeat (2) @(negedge clk_i);

    $display("TEST PASS");
    $finish;
  end

  // Watchdog
  initial begin
    #(TEST_CYCLES * 100 * 2);
    report_error("timeout, the test sequence did not finish in time");
  end

endmodule

// File: irq_ctrl_top.f
+incdir+src
src/irq_ctrl_pkg.sv
src/irq_csr_apb.sv
src/irq_arbiter.sv
src/bus_outstanding.sv
src/sleep_ctrl.sv
src/irq_ctrl_top.sv
dv/irq_ctrl_tb.sv

// File: src/bus_outstanding.sv
// Outstanding transaction counter and busy flag for one bus side
`include "irq_ctrl_macros.svh"

module bus_outstanding
  import irq_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // Observed handshake of this side
  input  bus_status_t bus_i,

  // High while anything is in flight
  output logic        busy_o
);

  logic                      start;
  logic                      done;
  logic [`OUTSTANDING_W-1:0] cnt_q;

  // Address phase accepted
  assign start = bus_i.req & bus_i.gnt;
  // Response phase
  assign done  = bus_i.rvalid;

  // Start and end together leave the count alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (start && !done) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (!start && done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign busy_o = |cnt_q;

endmodule

// File: src/irq_arbiter.sv
// MIP sampling register, fixed-priority interrupt selection and ack pulse register
`include "irq_ctrl_macros.svh"

module irq_arbiter
  import irq_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  input  irq_vec_t irq_i,
  input  irq_vec_t mie_i,
  input  logic     mstatus_mie_i,

  output irq_vec_t mip_o,
  output logic     wake_o,
  output logic     irq_ack_o,
  output irq_id_t  irq_id_o
);

  irq_vec_t mip_q;
  irq_vec_t pend_en;
  logic     win_valid;
  irq_id_t  win_id;
  logic     take;
  logic     irq_ack_q;
  irq_id_t  irq_id_q;

  // ----------------------------------------------------------------------
  // Pending register
  // ----------------------------------------------------------------------
  // Reserved lines never show up in MIP
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & `IRQ_VALID_MASK;
    end
  end

  assign pend_en = mip_q & mie_i;
  // Wake ignores the global enable
  assign wake_o  = |pend_en;

  // ----------------------------------------------------------------------
  // Winner selection
  // ----------------------------------------------------------------------
  // Lowest priority assigned first, later hits override
  // Order high to low: 31..16, 11, 3, 7
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pend_en[7]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(7);
    end
    if (pend_en[3]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(3);
    end
    if (pend_en[11]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(11);
    end
    // Platform lines, higher index wins
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pend_en[i]) begin
        win_valid = 1'b1;
        win_id    = irq_id_t'(i);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Acknowledge
  // ----------------------------------------------------------------------
  // MSTATUS.MIE drops on the edge after the ack, so block a second take meanwhile
  assign take = win_valid & mstatus_mie_i & ~irq_ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_ack_q <= 1'b0;
      irq_id_q  <= '0;
    end else begin
      irq_ack_q <= take;
      // Id only meaningful with the ack, zero otherwise
      irq_id_q  <= take ? win_id : '0;
    end
  end

  assign mip_o     = mip_q;
  assign irq_ack_o = irq_ack_q;
  assign irq_id_o  = irq_id_q;

endmodule

// File: src/irq_csr_apb.sv
// APB slave with the MIE and MSTATUS.MIE registers and read access to MIP
`include "irq_ctrl_macros.svh"

module irq_csr_apb
  import irq_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,

  // APB slave port
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,

  // From the arbiter
  input  irq_vec_t mip_i,
  input  logic     irq_ack_i,

  // To the arbiter and the sleep controller
  output irq_vec_t mie_o,
  output logic     mstatus_mie_o
);

  // ----------------------------------------------------------------------
  // Access decode
  // ----------------------------------------------------------------------
  logic      access;
  logic      wr_en;
  logic      rd_en;
  logic      addr_hit;
  apb_data_t rdata;

  irq_vec_t  mie_q;
  logic      mstatus_mie_q;

  // Zero wait states, so the access phase is the transfer
  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;
  assign rd_en  = access & ~apb_req_i.pwrite;

  // Read mux, unmapped offsets fall through to zero
  always_comb begin
    rdata    = '0;
    addr_hit = 1'b1;
    case (apb_req_i.paddr)
      `CSR_MIE_OFF: rdata = mie_q;
      `CSR_MSTATUS_OFF: rdata[`MSTATUS_MIE_BIT] = mstatus_mie_q;
      `CSR_MIP_OFF: rdata = mip_i;
      default: addr_hit = 1'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------

  // MIE keeps only implemented lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q <= '0;
    end else if (wr_en && (apb_req_i.paddr == `CSR_MIE_OFF)) begin
      mie_q <= apb_req_i.pwdata & `IRQ_VALID_MASK;
    end
  end

  // Global enable
  // Taking an interrupt clears it, like a trap entry; this wins over a write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q <= 1'b0;
    end else if (irq_ack_i) begin
      mstatus_mie_q <= 1'b0;
    end else if (wr_en && (apb_req_i.paddr == `CSR_MSTATUS_OFF)) begin
      mstatus_mie_q <= apb_req_i.pwdata[`MSTATUS_MIE_BIT];
    end
  end
  // MIP is read only, a write to it is simply dropped

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------
  assign apb_rsp_o.prdata  = rd_en ? rdata : '0;
  assign apb_rsp_o.pready  = 1'b1;
  // Error only on the access phase of an unmapped offset
  assign apb_rsp_o.pslverr = access & ~addr_hit;

  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;

endmodule

// File: src/irq_ctrl_macros.svh
// Interrupt count, valid mask, CSR offsets, sleep delay and counter width macros
`ifndef IRQ_CTRL_MACROS_SVH
`define IRQ_CTRL_MACROS_SVH

// ----------------------------------------------------------------------
// Interrupt lines
// ----------------------------------------------------------------------
`define IRQ_NUM 32
// Implemented lines: 31..16 platform, 11 external, 7 timer, 3 software
`define IRQ_VALID_MASK 32'hFFFF_0888

// ----------------------------------------------------------------------
// CSR map
// ----------------------------------------------------------------------
`define CSR_MIE_OFF 8'h00
`define CSR_MSTATUS_OFF 8'h04
`define CSR_MIP_OFF 8'h08
// Global machine interrupt enable inside MSTATUS
`define MSTATUS_MIE_BIT 3

// ----------------------------------------------------------------------
// Sleep controller
// ----------------------------------------------------------------------
// Cycles between a retired WFI and the drain check
`define WFI_SLEEP_DELAY 2
// Outstanding counter width, up to 3 transactions per side
`define OUTSTANDING_W 2

`endif

// File: src/irq_ctrl_pkg.sv
// Interrupt vector and id types, APB and bus status structs, sleep state enum
package irq_ctrl_pkg;

  // One bit per interrupt line
  typedef logic [31:0] irq_vec_t;
  // Interrupt id as reported with the ack
  typedef logic [4:0] irq_id_t;

  typedef logic [7:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // APB requester side
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // APB completer side
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Handshake view of one bus side, observed only
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
  } bus_status_t;

  typedef enum logic [1:0] {
    SLEEP_IDLE   = 2'd0,
    SLEEP_DELAY  = 2'd1,
    SLEEP_DRAIN  = 2'd2,
    SLEEP_ACTIVE = 2'd3
  } sleep_state_e;

endpackage

// File: src/irq_ctrl_top.sv
// Top level of the interrupt and sleep controller, CSR, arbiter, bus counters, sleep FSM
module irq_ctrl_top
  import irq_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  // CSR access
  input  apb_req_t    apb_req_i,
  output apb_rsp_t    apb_rsp_o,

  // Interrupt interface
  input  irq_vec_t    irq_i,
  output logic        irq_ack_o,
  output irq_id_t     irq_id_o,

  // Sleep control
  input  logic        wfi_i,
  input  logic        debug_req_i,
  input  bus_status_t instr_bus_i,
  input  bus_status_t data_bus_i,
  output logic        core_sleep_o
);

  irq_vec_t mie;
  irq_vec_t mip;
  logic     mstatus_mie;
  logic     wake;
  logic     irq_ack;
  logic     instr_busy;
  logic     data_busy;

  // ----------------------------------------------------------------------
  // CSR block
  // ----------------------------------------------------------------------
  irq_csr_apb i_csr (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .apb_req_i     (apb_req_i),
    .apb_rsp_o     (apb_rsp_o),
    .mip_i         (mip),
    .irq_ack_i     (irq_ack),
    .mie_o         (mie),
    .mstatus_mie_o (mstatus_mie)
  );

  // ----------------------------------------------------------------------
  // Pending sampling and arbitration
  // ----------------------------------------------------------------------
  irq_arbiter i_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .mip_o         (mip),
    .wake_o        (wake),
    .irq_ack_o     (irq_ack),
    .irq_id_o      (irq_id_o)
  );

  // Ack goes out and back into the CSR block
  assign irq_ack_o = irq_ack;

  // ----------------------------------------------------------------------
  // Bus drain tracking
  // ----------------------------------------------------------------------
  bus_outstanding i_instr_outstanding (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus_i  (instr_bus_i),
    .busy_o (instr_busy)
  );

  bus_outstanding i_data_outstanding (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus_i  (data_bus_i),
    .busy_o (data_busy)
  );

  // ----------------------------------------------------------------------
  // Sleep FSM
  // ----------------------------------------------------------------------
  sleep_ctrl i_sleep (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wfi_i        (wfi_i),
    .wake_i       (wake),
    .debug_req_i  (debug_req_i),
    .instr_busy_i (instr_busy),
    .data_busy_i  (data_busy),
    .core_sleep_o (core_sleep_o)
  );

endmodule

// File: src/sleep_ctrl.sv
// WFI sleep FSM with entry delay, bus drain wait and wake handling
`include "irq_ctrl_macros.svh"

module sleep_ctrl
  import irq_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,

  // Retired WFI, one cycle
  input  logic wfi_i,
  // Pending and enabled interrupt from the arbiter
  input  logic wake_i,
  input  logic debug_req_i,

  // Bus sides still busy
  input  logic instr_busy_i,
  input  logic data_busy_i,

  output logic core_sleep_o
);

  // Wide enough to hold the entry delay
  typedef logic [$clog2(`WFI_SLEEP_DELAY + 1)-1:0] dly_cnt_t;

  sleep_state_e state_q;
  sleep_state_e state_d;
  dly_cnt_t     dly_q;
  dly_cnt_t     dly_d;
  logic         wake;
  logic         busy;
  logic         core_sleep_q;

  assign wake = wake_i | debug_req_i;
  assign busy = instr_busy_i | data_busy_i;

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    dly_d   = dly_q;
    case (state_q)
      SLEEP_IDLE: begin
        // WFI under a live wake condition falls straight through
        if (wfi_i && !wake) begin
          state_d = SLEEP_DELAY;
          dly_d   = dly_cnt_t'(`WFI_SLEEP_DELAY - 1);
        end
      end
      SLEEP_DELAY: begin
        if (wake) begin
          state_d = SLEEP_IDLE;
        end else if (dly_q == '0) begin
          state_d = busy ? SLEEP_DRAIN : SLEEP_ACTIVE;
        end else begin
          dly_d = dly_q - 1'b1;
        end
      end
      SLEEP_DRAIN: begin
        // Wait for both sides to go quiet
        if (wake) begin
          state_d = SLEEP_IDLE;
        end else if (!busy) begin
          state_d = SLEEP_ACTIVE;
        end
      end
      SLEEP_ACTIVE: begin
        if (wake) begin
          state_d = SLEEP_IDLE;
        end
      end
      default: state_d = SLEEP_IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // State and output registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= SLEEP_IDLE;
      dly_q        <= '0;
      core_sleep_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      dly_q        <= dly_d;
      // Registered copy of the ACTIVE state
      core_sleep_q <= (state_d == SLEEP_ACTIVE);
    end
  end

  assign core_sleep_o = core_sleep_q;

endmodule
